// File: include/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// byte address width on every AR/AW channel
`define MEM_ADDR_W 32

// 32-bit words in the on-chip array
// valid byte range is 0 .. MEM_DEPTH_WORDS*4-1
`define MEM_DEPTH_WORDS 256

// upper bound of wait cycles per access, lower bound is 1
`define MEM_MAX_DELAY 4

// reset value of the 8-bit wait-state LFSR, must be nonzero
`define MEM_LFSR_SEED 8'hA5

`endif

// File: hw/axi_lite_pkg.sv
`default_nettype none

`include "mem_defines.svh"

package axi_lite_pkg;

    // AXI response codes, only the two we ever return
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    // read address channel
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
    } axi_ar_t;

    // read data channel
    typedef struct packed {
        logic [31:0] data;
        resp_e       resp;
    } axi_r_t;

    // write address channel
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
    } axi_aw_t;

    // write data channel, one strobe bit per byte lane
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

    // write response channel
    typedef struct packed {
        resp_e resp;
    } axi_b_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT,
        RD_RESP
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_COLLECT,
        WR_WAIT,
        WR_RESP
    } wr_state_e;

    // read-side owner in the arbiter
    typedef enum logic {
        OWN_IFU,
        OWN_LSU
    } arb_owner_e;

endpackage

`default_nettype wire

// File: hw/sram_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module sram_array (
    input  logic                                clk,
    // read port, data shows up one cycle after rd_en
    input  logic                                rd_en,
    input  logic [$clog2(`MEM_DEPTH_WORDS)-1:0] rd_idx,
    output logic [31:0]                         rd_data,
    // write port with byte lanes
    input  logic                                wr_en,
    input  logic [$clog2(`MEM_DEPTH_WORDS)-1:0] wr_idx,
    input  logic [31:0]                         wr_data,
    input  logic [3:0]                          wr_strb
);

    // word storage
    logic [31:0] mem [`MEM_DEPTH_WORDS];

    // byte lane writes, untouched lanes keep old contents
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    // registered read, holds value until the next rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

// File: hw/sram_axi_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module sram_axi_slave
    import axi_lite_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    // read channels
    input  axi_ar_t                             ar,
    input  logic                                ar_valid,
    output logic                                ar_ready,
    output axi_r_t                              r,
    output logic                                r_valid,
    input  logic                                r_ready,
    // write channels
    input  axi_aw_t                             aw,
    input  logic                                aw_valid,
    output logic                                aw_ready,
    input  axi_w_t                              w,
    input  logic                                w_valid,
    output logic                                w_ready,
    output axi_b_t                              b,
    output logic                                b_valid,
    input  logic                                b_ready,
    // array side
    output logic                                rd_en,
    output logic [$clog2(`MEM_DEPTH_WORDS)-1:0] rd_idx,
    input  logic [31:0]                         rd_data,
    output logic                                wr_en,
    output logic [$clog2(`MEM_DEPTH_WORDS)-1:0] wr_idx,
    output logic [31:0]                         wr_data,
    output logic [3:0]                          wr_strb
);

    localparam int IDX_W = $clog2(`MEM_DEPTH_WORDS);
    localparam int CNT_W = $clog2(`MEM_MAX_DELAY + 1);

    rd_state_e              rd_state;
    wr_state_e              wr_state;
    logic [7:0]             lfsr;
    logic [CNT_W-1:0]       rd_cnt;
    logic [CNT_W-1:0]       wr_cnt;
    logic [`MEM_ADDR_W-1:0] rd_addr;
    logic [`MEM_ADDR_W-1:0] wr_addr;
    logic                   aw_got;
    logic                   w_got;
    logic                   rd_ok;
    logic                   wr_ok;
    logic                   aw_fire;
    logic                   w_fire;

    // wait length 1..MAX taken from the lfsr
    function automatic logic [CNT_W-1:0] wait_cycles(input logic [7:0] v);
        return CNT_W'(v % `MEM_MAX_DELAY) + CNT_W'(1);
    endfunction

    // inside the 1 KiB window
    function automatic logic addr_ok(input logic [`MEM_ADDR_W-1:0] a);
        return a < `MEM_ADDR_W'(`MEM_DEPTH_WORDS * 4);
    endfunction

    // free running lfsr, x^8+x^6+x^5+x^4+1
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= `MEM_LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    // read engine
    assign ar_ready = (rd_state == RD_IDLE);
    assign r_valid  = (rd_state == RD_RESP);
    assign rd_ok    = addr_ok(rd_addr);
    assign rd_idx   = rd_addr[IDX_W+1:2];
    // array read in the last wait cycle, skipped when out of range
    assign rd_en    = (rd_state == RD_WAIT) && (rd_cnt == CNT_W'(1)) && rd_ok;
    assign r.data   = rd_ok ? rd_data : 32'h0;
    assign r.resp   = rd_ok ? OKAY : SLVERR;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= RD_IDLE;
            rd_cnt   <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (ar_valid) begin
                        rd_state <= RD_WAIT;
                        rd_cnt   <= wait_cycles(lfsr);
                    end
                end
                RD_WAIT: begin
                    if (rd_cnt == CNT_W'(1)) begin
                        rd_state <= RD_RESP;
                    end else begin
                        rd_cnt <= rd_cnt - CNT_W'(1);
                    end
                end
                RD_RESP: begin
                    // back to idle, ar_ready rises next cycle
                    if (r_ready) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            rd_addr <= ar.addr;
        end
    end

    // write engine, aw and w accepted in any order
    assign aw_ready = (wr_state == WR_COLLECT) && !aw_got;
    assign w_ready  = (wr_state == WR_COLLECT) && !w_got;
    assign aw_fire  = aw_valid && aw_ready;
    assign w_fire   = w_valid && w_ready;
    assign b_valid  = (wr_state == WR_RESP);
    assign wr_ok    = addr_ok(wr_addr);
    assign wr_idx   = wr_addr[IDX_W+1:2];
    // write lands on the same edge that raises b_valid
    assign wr_en    = (wr_state == WR_WAIT) && (wr_cnt == CNT_W'(1)) && wr_ok;
    assign b.resp   = wr_ok ? OKAY : SLVERR;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= WR_COLLECT;
            wr_cnt   <= '0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
        end else begin
            case (wr_state)
                WR_COLLECT: begin
                    if (aw_fire) begin
                        aw_got <= 1'b1;
                    end
                    if (w_fire) begin
                        w_got <= 1'b1;
                    end
                    // both halves present, start the wait
                    if ((aw_got || aw_fire) && (w_got || w_fire)) begin
                        wr_state <= WR_WAIT;
                        wr_cnt   <= wait_cycles(lfsr);
                    end
                end
                WR_WAIT: begin
                    if (wr_cnt == CNT_W'(1)) begin
                        wr_state <= WR_RESP;
                    end else begin
                        wr_cnt <= wr_cnt - CNT_W'(1);
                    end
                end
                WR_RESP: begin
                    if (b_ready) begin
                        wr_state <= WR_COLLECT;
                        aw_got   <= 1'b0;
                        w_got    <= 1'b0;
                    end
                end
                default: wr_state <= WR_COLLECT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_addr <= aw.addr;
        end
        if (w_fire) begin
            wr_data <= w.data;
            wr_strb <= w.strb;
        end
    end

    // stalled read response must not move
    a_r_stable: assert property (@(posedge clk) disable iff (rst)
        r_valid && !r_ready |=> r_valid && $stable(r));

    // a write response needs a W beat taken since the last B
    a_b_after_w: assert property (@(posedge clk) disable iff (rst)
        $rose(b_valid) |-> w_got);

endmodule

`default_nettype wire

// File: hw/axi_lite_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_arbiter
    import axi_lite_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    // fetch master, read only
    input  axi_ar_t ifu_ar,
    input  logic    ifu_ar_valid,
    output logic    ifu_ar_ready,
    output axi_r_t  ifu_r,
    output logic    ifu_r_valid,
    input  logic    ifu_r_ready,
    // load/store master
    input  axi_ar_t lsu_ar,
    input  logic    lsu_ar_valid,
    output logic    lsu_ar_ready,
    output axi_r_t  lsu_r,
    output logic    lsu_r_valid,
    input  logic    lsu_r_ready,
    input  axi_aw_t lsu_aw,
    input  logic    lsu_aw_valid,
    output logic    lsu_aw_ready,
    input  axi_w_t  lsu_w,
    input  logic    lsu_w_valid,
    output logic    lsu_w_ready,
    output axi_b_t  lsu_b,
    output logic    lsu_b_valid,
    input  logic    lsu_b_ready,
    // toward the slave
    output axi_ar_t mem_ar,
    output logic    mem_ar_valid,
    input  logic    mem_ar_ready,
    input  axi_r_t  mem_r,
    input  logic    mem_r_valid,
    output logic    mem_r_ready,
    output axi_aw_t mem_aw,
    output logic    mem_aw_valid,
    input  logic    mem_aw_ready,
    output axi_w_t  mem_w,
    output logic    mem_w_valid,
    input  logic    mem_w_ready,
    input  axi_b_t  mem_b,
    input  logic    mem_b_valid,
    output logic    mem_b_ready
);

    logic       busy;
    arb_owner_e owner;
    arb_owner_e last;
    arb_owner_e pick;
    logic       gnt_ifu;
    logic       gnt_lsu;

    // round robin, on a tie the master not served last wins
    always_comb begin
        if (ifu_ar_valid && lsu_ar_valid) begin
            pick = (last == OWN_IFU) ? OWN_LSU : OWN_IFU;
        end else if (lsu_ar_valid) begin
            pick = OWN_LSU;
        end else begin
            pick = OWN_IFU;
        end
    end

    // grant held from AR until the owner's R beat
    assign gnt_ifu = busy ? (owner == OWN_IFU) : (ifu_ar_valid && pick == OWN_IFU);
    assign gnt_lsu = busy ? (owner == OWN_LSU) : (lsu_ar_valid && pick == OWN_LSU);

    // AR forwarded in the same cycle
    assign mem_ar       = (pick == OWN_LSU) ? lsu_ar : ifu_ar;
    assign mem_ar_valid = !busy && (ifu_ar_valid || lsu_ar_valid);
    assign ifu_ar_ready = !busy && gnt_ifu && mem_ar_ready;
    assign lsu_ar_ready = !busy && gnt_lsu && mem_ar_ready;

    // R goes back to the owner only
    assign ifu_r       = mem_r;
    assign lsu_r       = mem_r;
    assign ifu_r_valid = busy && gnt_ifu && mem_r_valid;
    assign lsu_r_valid = busy && gnt_lsu && mem_r_valid;
    assign mem_r_ready = busy && (gnt_ifu ? ifu_r_ready : lsu_r_ready);

    // write side belongs to the lsu alone
    assign mem_aw       = lsu_aw;
    assign mem_aw_valid = lsu_aw_valid;
    assign lsu_aw_ready = mem_aw_ready;
    assign mem_w        = lsu_w;
    assign mem_w_valid  = lsu_w_valid;
    assign lsu_w_ready  = mem_w_ready;
    assign lsu_b        = mem_b;
    assign lsu_b_valid  = mem_b_valid;
    assign mem_b_ready  = lsu_b_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            owner <= OWN_IFU;
            // fetch gets the first tie
            last  <= OWN_LSU;
        end else if (mem_ar_valid && mem_ar_ready) begin
            busy  <= 1'b1;
            owner <= pick;
        end else if (mem_r_valid && mem_r_ready) begin
            busy <= 1'b0;
            last <= owner;
        end
    end

    // slave only answers a read we forwarded, and only to its owner
    a_r_one_owner: assert property (@(posedge clk) disable iff (rst)
        mem_r_valid |-> busy && (ifu_r_valid ^ lsu_r_valid)
                        && (ifu_r_valid == (owner == OWN_IFU)));

endmodule

`default_nettype wire

// File: hw/mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module mem_subsystem_top
    import axi_lite_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  axi_ar_t ifu_ar,
    input  logic    ifu_ar_valid,
    output logic    ifu_ar_ready,
    output axi_r_t  ifu_r,
    output logic    ifu_r_valid,
    input  logic    ifu_r_ready,
    input  axi_ar_t lsu_ar,
    input  logic    lsu_ar_valid,
    output logic    lsu_ar_ready,
    output axi_r_t  lsu_r,
    output logic    lsu_r_valid,
    input  logic    lsu_r_ready,
    input  axi_aw_t lsu_aw,
    input  logic    lsu_aw_valid,
    output logic    lsu_aw_ready,
    input  axi_w_t  lsu_w,
    input  logic    lsu_w_valid,
    output logic    lsu_w_ready,
    output axi_b_t  lsu_b,
    output logic    lsu_b_valid,
    input  logic    lsu_b_ready
);

    // arbiter to slave
    axi_ar_t mem_ar;
    logic    mem_ar_valid;
    logic    mem_ar_ready;
    axi_r_t  mem_r;
    logic    mem_r_valid;
    logic    mem_r_ready;
    axi_aw_t mem_aw;
    logic    mem_aw_valid;
    logic    mem_aw_ready;
    axi_w_t  mem_w;
    logic    mem_w_valid;
    logic    mem_w_ready;
    axi_b_t  mem_b;
    logic    mem_b_valid;
    logic    mem_b_ready;

    // slave to array
    logic                                rd_en;
    logic [$clog2(`MEM_DEPTH_WORDS)-1:0] rd_idx;
    logic [31:0]                         rd_data;
    logic                                wr_en;
    logic [$clog2(`MEM_DEPTH_WORDS)-1:0] wr_idx;
    logic [31:0]                         wr_data;
    logic [3:0]                          wr_strb;

    // port names line up with the wires above
    axi_lite_arbiter u_arbiter (.*);

    sram_axi_slave u_slave (
        .clk      (clk),
        .rst      (rst),
        .ar       (mem_ar),
        .ar_valid (mem_ar_valid),
        .ar_ready (mem_ar_ready),
        .r        (mem_r),
        .r_valid  (mem_r_valid),
        .r_ready  (mem_r_ready),
        .aw       (mem_aw),
        .aw_valid (mem_aw_valid),
        .aw_ready (mem_aw_ready),
        .w        (mem_w),
        .w_valid  (mem_w_valid),
        .w_ready  (mem_w_ready),
        .b        (mem_b),
        .b_valid  (mem_b_valid),
        .b_ready  (mem_b_ready),
        .rd_en    (rd_en),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb)
    );

    sram_array u_array (.*);

endmodule

`default_nettype wire

// File: sim/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module tb_mem_subsystem
    import axi_lite_pkg::*;
();

    localparam int RST_CYCLES = 3;
    localparam int IDLE_CYCLES = 3;

    logic    clk;
    logic    rst;
    axi_ar_t ifu_ar;
    logic    ifu_ar_valid;
    logic    ifu_ar_ready;
    axi_r_t  ifu_r;
    logic    ifu_r_valid;
    logic    ifu_r_ready;
    axi_ar_t lsu_ar;
    logic    lsu_ar_valid;
    logic    lsu_ar_ready;
    axi_r_t  lsu_r;
    logic    lsu_r_valid;
    logic    lsu_r_ready;
    axi_aw_t lsu_aw;
    logic    lsu_aw_valid;
    logic    lsu_aw_ready;
    axi_w_t  lsu_w;
    logic    lsu_w_valid;
    logic    lsu_w_ready;
    axi_b_t  lsu_b;
    logic    lsu_b_valid;
    logic    lsu_b_ready;

    // a request is outstanding on that response channel
    logic   ifu_pend;
    logic   lsu_pend;
    logic   b_pend;
    // AW or W beat already accepted for the write in progress
    logic   aw_taken;
    logic   w_taken;
    // snapshot taken at the last negedge for the stall checks
    logic   ifu_stall;
    logic   lsu_stall;
    logic   b_stall;
    axi_r_t ifu_r_prev;
    axi_r_t lsu_r_prev;
    axi_b_t b_prev;
    string  ifu_test;
    string  lsu_test;
    int     cyc;
    int     limit;

    // pattern table with one entry per file line
    string       pat_name[$];
    string       pat_master[$];
    string       pat_op[$];
    logic [31:0] pat_addr[$];
    logic [31:0] pat_data[$];
    logic [3:0]  pat_strb[$];
    logic [31:0] pat_exp[$];
    logic [1:0]  pat_resp[$];

    mem_subsystem_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        string       name;
        string       master;
        string       op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp_data;
        logic [3:0]  strb;
        logic [1:0]  resp;
        fd = $fopen("sim/mem_patterns.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the pattern file sim/mem_patterns.txt");
            stop_on_failure();
        end
        while ($fgets(line, fd) != 0) begin
            // skip blank and comment lines
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %s %s %h %h %h %h %h",
                        name, master, op, addr, data, strb, exp_data, resp);
            assert (n == 8) else begin
                $display("malformed pattern line: %s", line);
                stop_on_failure();
            end
            pat_name.push_back(name);
            pat_master.push_back(master);
            pat_op.push_back(op);
            pat_addr.push_back(addr);
            pat_data.push_back(data);
            pat_strb.push_back(strb);
            pat_exp.push_back(exp_data);
            pat_resp.push_back(resp);
        end
        $fclose(fd);
    endtask

    // one read on either master with rready withheld at random
    task automatic read_txn(input logic is_lsu, input string name, input logic [31:0] addr,
                            input logic [31:0] exp_data, input logic [1:0] exp_resp);
        axi_r_t got;
        @(posedge clk);
        if (is_lsu) begin
            lsu_test = name;
            lsu_ar.addr  <= addr;
            lsu_ar_valid <= 1'b1;
            lsu_pend = 1'b1;
        end else begin
            ifu_test = name;
            ifu_ar.addr  <= addr;
            ifu_ar_valid <= 1'b1;
            ifu_pend = 1'b1;
        end
        // hold AR until the arbiter takes it
        do begin
            @(negedge clk);
        end while (!(is_lsu ? lsu_ar_ready : ifu_ar_ready));
        @(posedge clk);
        if (is_lsu) begin
            lsu_ar_valid <= 1'b0;
        end else begin
            ifu_ar_valid <= 1'b0;
        end
        // about one cycle in four without rready
        forever begin
            if (is_lsu) begin
                lsu_r_ready <= ($urandom % 4) != 0;
            end else begin
                ifu_r_ready <= ($urandom % 4) != 0;
            end
            @(negedge clk);
            if (is_lsu ? (lsu_r_valid && lsu_r_ready) : (ifu_r_valid && ifu_r_ready)) begin
                break;
            end
            @(posedge clk);
        end
        got = is_lsu ? lsu_r : ifu_r;
        @(posedge clk);
        if (is_lsu) begin
            lsu_r_ready <= 1'b0;
            lsu_pend = 1'b0;
        end else begin
            ifu_r_ready <= 1'b0;
            ifu_pend = 1'b0;
        end
        assert (got.data == exp_data && got.resp == exp_resp) else begin
            $display("Error %s: expected data %h resp %0d, actual data %h resp %0d",
                     name, exp_data, exp_resp, got.data, got.resp);
            stop_on_failure();
        end
    endtask

    // lsu write where W may trail AW by a cycle
    task automatic write_txn(input string name, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] strb,
                             input logic [1:0] exp_resp);
        axi_b_t got;
        lsu_test = name;
        fork
            begin
                @(posedge clk);
                lsu_aw.addr  <= addr;
                lsu_aw_valid <= 1'b1;
                b_pend = 1'b1;
                do begin
                    @(negedge clk);
                end while (!lsu_aw_ready);
                @(posedge clk);
                lsu_aw_valid <= 1'b0;
                aw_taken = 1'b1;
            end
            begin
                repeat (1 + $urandom % 2) @(posedge clk);
                lsu_w.data  <= data;
                lsu_w.strb  <= strb;
                lsu_w_valid <= 1'b1;
                do begin
                    @(negedge clk);
                end while (!lsu_w_ready);
                @(posedge clk);
                lsu_w_valid <= 1'b0;
                w_taken = 1'b1;
            end
        join
        forever begin
            lsu_b_ready <= ($urandom % 4) != 0;
            @(negedge clk);
            if (lsu_b_valid && lsu_b_ready) begin
                break;
            end
            @(posedge clk);
        end
        got = lsu_b;
        @(posedge clk);
        lsu_b_ready <= 1'b0;
        b_pend = 1'b0;
        aw_taken = 1'b0;
        w_taken = 1'b0;
        assert (got.resp == exp_resp) else begin
            $display("Error %s: expected resp %0d, actual resp %0d", name, exp_resp, got.resp);
            stop_on_failure();
        end
    endtask

    // protocol monitor sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            assert (!(ifu_ar_ready && lsu_ar_ready)) else begin
                $display("arready was high for both masters in the same cycle");
                stop_on_failure();
            end
            // also covers stray responses right after reset
            assert ((!ifu_r_valid || ifu_pend) && (!lsu_r_valid || lsu_pend)) else begin
                $display("a read response arrived with no read outstanding");
                stop_on_failure();
            end
            assert (!lsu_b_valid || b_pend) else begin
                $display("a write response arrived with no write outstanding");
                stop_on_failure();
            end
            // each write ready drops after its own beat and returns after B
            assert (lsu_aw_ready == !aw_taken && lsu_w_ready == !w_taken) else begin
                $display("Error %s: expected aw_ready %b w_ready %b, actual aw_ready %b w_ready %b",
                         lsu_test, !aw_taken, !w_taken, lsu_aw_ready, lsu_w_ready);
                stop_on_failure();
            end
            assert (!ifu_stall || (ifu_r_valid && ifu_r == ifu_r_prev)) else begin
                $display("Error %s: stalled ifu R expected %h, actual valid %b payload %h",
                         ifu_test, ifu_r_prev, ifu_r_valid, ifu_r);
                stop_on_failure();
            end
            assert (!lsu_stall || (lsu_r_valid && lsu_r == lsu_r_prev)) else begin
                $display("Error %s: stalled lsu R expected %h, actual valid %b payload %h",
                         lsu_test, lsu_r_prev, lsu_r_valid, lsu_r);
                stop_on_failure();
            end
            assert (!b_stall || (lsu_b_valid && lsu_b == b_prev)) else begin
                $display("Error %s: stalled B expected %h, actual valid %b payload %h",
                         lsu_test, b_prev, lsu_b_valid, lsu_b);
                stop_on_failure();
            end
        end
        ifu_stall  = ifu_r_valid && !ifu_r_ready;
        lsu_stall  = lsu_r_valid && !lsu_r_ready;
        b_stall    = lsu_b_valid && !lsu_b_ready;
        ifu_r_prev = ifu_r;
        lsu_r_prev = lsu_r;
        b_prev     = lsu_b;
    end

    // cycle budget from the pattern count
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (limit > 0 && cyc >= limit) begin
            $display("timeout after %0d cycles, a transaction never completed", cyc);
            stop_on_failure();
        end
    end

    initial begin
        int i;
        void'($urandom(32'hdf11_5ee5));
        rst          = 1'b1;
        ifu_ar       = '0;
        ifu_ar_valid = 1'b0;
        ifu_r_ready  = 1'b0;
        lsu_ar       = '0;
        lsu_ar_valid = 1'b0;
        lsu_r_ready  = 1'b0;
        lsu_aw       = '0;
        lsu_aw_valid = 1'b0;
        lsu_w        = '0;
        lsu_w_valid  = 1'b0;
        lsu_b_ready  = 1'b0;
        ifu_pend     = 1'b0;
        lsu_pend     = 1'b0;
        b_pend       = 1'b0;
        aw_taken     = 1'b0;
        w_taken      = 1'b0;
        ifu_stall    = 1'b0;
        lsu_stall    = 1'b0;
        b_stall      = 1'b0;
        cyc          = 0;
        limit        = 0;
        load_patterns();
        limit = RST_CYCLES + IDLE_CYCLES + pat_name.size() * (`MEM_MAX_DELAY + 12);
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        // quiet stretch where nothing may answer yet
        repeat (IDLE_CYCLES) @(posedge clk);
        i = 0;
        while (i < pat_name.size()) begin
            if (pat_master[i] == "pair" && i + 1 < pat_name.size()) begin
                fork
                    read_txn(1'b0, pat_name[i], pat_addr[i], pat_exp[i], pat_resp[i]);
                    read_txn(1'b1, pat_name[i+1], pat_addr[i+1], pat_exp[i+1], pat_resp[i+1]);
                join
                i += 2;
            end else begin
                if (pat_op[i] == "W") begin
                    write_txn(pat_name[i], pat_addr[i], pat_data[i], pat_strb[i], pat_resp[i]);
                end else begin
                    read_txn(pat_master[i] == "lsu", pat_name[i], pat_addr[i],
                             pat_exp[i], pat_resp[i]);
                end
                i += 1;
            end
        end
        repeat (2) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
hw/axi_lite_pkg.sv
hw/sram_array.sv
hw/sram_axi_slave.sv
hw/axi_lite_arbiter.sv
hw/mem_subsystem_top.sv
sim/tb_mem_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the memory subsystem testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_mem_subsystem -Mdir obj_dir -o tb_mem_subsystem
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_mem_subsystem > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

# the log decides pass or fail
if grep -q "ERRORS FOUND" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
echo "simulation passed"
exit 0

// File: sim/mem_patterns.txt
# name master op addr data strb exp_data exp_resp, all numbers in hex
# a pair line is an ifu read issued on the same edge as the lsu read on the next line
wr_word_a      lsu  W 00000010 deadbeef f 00000000 0
rd_word_a_lsu  lsu  R 00000010 00000000 0 deadbeef 0
rd_word_a_ifu  ifu  R 00000010 00000000 0 deadbeef 0
wr_word_b      lsu  W 00000020 11223344 f 00000000 0
wr_strb_lo     lsu  W 00000020 aabbccdd 3 00000000 0
rd_strb_lo     lsu  R 00000020 00000000 0 1122ccdd 0
wr_strb_hi     lsu  W 00000020 55667788 8 00000000 0
rd_strb_hi     ifu  R 00000020 00000000 0 5522ccdd 0
wr_strb_mid    lsu  W 00000020 99aabbee 6 00000000 0
rd_strb_mid    lsu  R 00000020 00000000 0 55aabbdd 0
wr_oor_alias   lsu  W 00000410 0badf00d f 00000000 2
rd_oor_lsu     lsu  R 00000410 00000000 0 00000000 2
rd_oor_ifu     ifu  R 00000400 00000000 0 00000000 2
rd_oor_top     lsu  R fffffffc 00000000 0 00000000 2
rd_alias_chk   ifu  R 00000010 00000000 0 deadbeef 0
wr_word_c      lsu  W 000003fc cafef00d f 00000000 0
pair_rd_1      pair R 00000010 00000000 0 deadbeef 0
pair_rd_1_lsu  lsu  R 000003fc 00000000 0 cafef00d 0
pair_rd_2      pair R 000003fc 00000000 0 cafef00d 0
pair_rd_2_lsu  lsu  R 00000020 00000000 0 55aabbdd 0
wr_oor_alias2  lsu  W 000007fc 12345678 f 00000000 2
rd_c_chk       ifu  R 000003fc 00000000 0 cafef00d 0
wr_strb_b0     lsu  W 000003fc 000000aa 1 00000000 0
rd_strb_b0     lsu  R 000003fc 00000000 0 cafef0aa 0
